// File: hw/uart_pkg.sv
// Shared frame widths, bit timing, FIFO sizing and FSM state types
// for the serial port RTL and its testbench
package uart_pkg;

    // Character format
    localparam int DATA_BITS = 8;

    // FIFO sizing, 16 entries
    localparam int FIFO_LOG2_DEPTH = 4;
    localparam int CNT_BITS = FIFO_LOG2_DEPTH + 1;

    // Serial bit time in clock cycles
    localparam int CLKS_PER_BIT = 8;
    localparam int BITCNT_BITS = $clog2(CLKS_PER_BIT + 1);

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// File: hw/sfifo.sv
// Synchronous show-ahead FIFO with write/read strobes and a fill count
// Head of queue is always visible on o_rdata
`timescale 1ns/1ns

module sfifo #(
    parameter int dbits = 8,
    parameter int log2_depth = 4
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_we,
    input  logic [dbits-1:0]      i_wdata,
    input  logic                  i_re,
    output logic [dbits-1:0]      o_rdata,
    output logic [log2_depth:0]   o_count
);

    localparam int DEPTH = 2 ** log2_depth;

    logic [dbits-1:0]      mem [DEPTH];
    logic [log2_depth-1:0] wr_ptr;
    logic [log2_depth-1:0] rd_ptr;
    logic [log2_depth:0]   total_cnt;
    logic                  full;
    logic                  empty;
    logic                  wr_take;
    logic                  rd_take;

    assign full  = total_cnt[log2_depth];
    assign empty = (total_cnt == '0);

    // A write into a full FIFO still lands when the head is popped in the same cycle
    assign wr_take = i_we && (!full || i_re);
    assign rd_take = i_re && !empty;

    always_ff @(posedge i_clk) begin
        if (wr_take) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            total_cnt <= '0;
        end else begin
            if (wr_take) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_take, rd_take})
                2'b10:   total_cnt <= total_cnt + 1'b1;
                2'b01:   total_cnt <= total_cnt - 1'b1;
                default: total_cnt <= total_cnt;
            endcase
        end
    end

    assign o_rdata = mem[rd_ptr];
    assign o_count = total_cnt;

    // Fill level stays within the buffer
    a_count_in_range: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_count <= DEPTH
    );

    // At most one push or one pop is reflected per clock
    a_count_step: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_count == $past(o_count)) ||
        (o_count == $past(o_count) + 1) ||
        (o_count == $past(o_count) - 1)
    );

endmodule

// File: hw/uart_tx.sv
// Serial transmitter, pops one byte per frame from the transmit FIFO
// Frame is start bit, data bits LSB first, stop bit
`timescale 1ns/1ns

module uart_tx (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic [uart_pkg::DATA_BITS-1:0] i_fifo_data,
    input  logic [uart_pkg::CNT_BITS-1:0]  i_fifo_count,
    output logic                           o_fifo_re,
    output logic                           o_txd
);

    uart_pkg::tx_state_e                     state;
    logic [uart_pkg::BITCNT_BITS-1:0]        bit_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0]  bit_idx;
    logic [uart_pkg::DATA_BITS-1:0]          shift;
    logic                                    bit_done;
    logic                                    shift_en;

    assign bit_done = (bit_cnt == uart_pkg::BITCNT_BITS'(uart_pkg::CLKS_PER_BIT - 1));

    // Pop the head as soon as we are idle and something is queued
    assign o_fifo_re = (state == uart_pkg::TX_IDLE) && (i_fifo_count != '0);
    assign shift_en  = (state == uart_pkg::TX_DATA) && bit_done;

    always_ff @(posedge i_clk) begin
        if (o_fifo_re) begin
            shift <= i_fifo_data;
        end else if (shift_en) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= uart_pkg::TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end else begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    bit_cnt <= '0;
                    if (o_fifo_re) begin
                        state <= uart_pkg::TX_START;
                        o_txd <= 1'b0;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        o_txd   <= shift[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == uart_pkg::DATA_BITS - 1) begin
                            state <= uart_pkg::TX_STOP;
                            o_txd <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            // Next bit before the shift takes effect
                            o_txd   <= shift[1];
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_done) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // Line rests high between frames
    a_idle_line_high: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (state == uart_pkg::TX_IDLE) |-> o_txd
    );

endmodule

// File: hw/uart_rx.sv
// Serial receiver, samples each bit at its middle and pushes good bytes
// into the receive FIFO; a low stop bit drops the byte and pulses o_frame_err
`timescale 1ns/1ns

module uart_rx (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_rxd,
    output logic                           o_fifo_we,
    output logic [uart_pkg::DATA_BITS-1:0] o_fifo_wdata,
    output logic                           o_frame_err
);

    uart_pkg::rx_state_e                     state;
    logic [uart_pkg::BITCNT_BITS-1:0]        bit_cnt;
    logic [$clog2(uart_pkg::DATA_BITS)-1:0]  bit_idx;
    logic                                    rxd_meta;
    logic                                    rxd_sync;
    logic                                    rxd_prev;
    logic                                    fall_edge;
    logic                                    half_done;
    logic                                    bit_done;
    logic                                    sample_en;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall_edge = rxd_prev && !rxd_sync;
    assign half_done = (bit_cnt == uart_pkg::BITCNT_BITS'(uart_pkg::CLKS_PER_BIT / 2 - 1));
    assign bit_done  = (bit_cnt == uart_pkg::BITCNT_BITS'(uart_pkg::CLKS_PER_BIT - 1));
    assign sample_en = (state == uart_pkg::RX_DATA) && bit_done;

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clk) begin
        if (sample_en) begin
            o_fifo_wdata <= {rxd_sync, o_fifo_wdata[uart_pkg::DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= uart_pkg::RX_IDLE;
            bit_cnt     <= '0;
            bit_idx     <= '0;
            o_fifo_we   <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            o_fifo_we   <= 1'b0;
            o_frame_err <= 1'b0;
            bit_cnt     <= bit_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    bit_cnt <= '0;
                    if (fall_edge) begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    // Half a bit in, confirm the start bit is real
                    if (half_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (bit_idx == uart_pkg::DATA_BITS - 1) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_done) begin
                        bit_cnt     <= '0;
                        o_fifo_we   <= rxd_sync;
                        o_frame_err <= !rxd_sync;
                        state       <= uart_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // A frame ends either in a push or in an error, never both
    a_we_err_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(o_fifo_we && o_frame_err)
    );

endmodule

// File: hw/uart_top.sv
// Serial port peripheral top level, host strobes on one side and
// the serial line on the other, with a FIFO in each direction
`timescale 1ns/1ns

module uart_top (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_tx_we,
    input  logic [uart_pkg::DATA_BITS-1:0] i_tx_wdata,
    output logic [uart_pkg::CNT_BITS-1:0]  o_tx_count,
    input  logic                           i_rx_re,
    output logic [uart_pkg::DATA_BITS-1:0] o_rx_rdata,
    output logic [uart_pkg::CNT_BITS-1:0]  o_rx_count,
    output logic                           o_frame_err,
    output logic                           o_txd,
    input  logic                           i_rxd
);

    logic                           tx_re;
    logic [uart_pkg::DATA_BITS-1:0] tx_head;
    logic                           rx_we;
    logic [uart_pkg::DATA_BITS-1:0] rx_wdata;

    // Host to line
    sfifo #(
        .dbits      (uart_pkg::DATA_BITS),
        .log2_depth (uart_pkg::FIFO_LOG2_DEPTH)
    ) tx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (i_tx_we),
        .i_wdata (i_tx_wdata),
        .i_re    (tx_re),
        .o_rdata (tx_head),
        .o_count (o_tx_count)
    );

    uart_tx u_tx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_fifo_data  (tx_head),
        .i_fifo_count (o_tx_count),
        .o_fifo_re    (tx_re),
        .o_txd        (o_txd)
    );

    // Line to host
    uart_rx u_rx (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_rxd        (i_rxd),
        .o_fifo_we    (rx_we),
        .o_fifo_wdata (rx_wdata),
        .o_frame_err  (o_frame_err)
    );

    sfifo #(
        .dbits      (uart_pkg::DATA_BITS),
        .log2_depth (uart_pkg::FIFO_LOG2_DEPTH)
    ) rx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (rx_we),
        .i_wdata (rx_wdata),
        .i_re    (i_rx_re),
        .o_rdata (o_rx_rdata),
        .o_count (o_rx_count)
    );

endmodule

// File: testbench/tb_uart.sv
// Table-driven testbench for the serial port peripheral, in loopback and with
// frames driven straight onto the receive line
`timescale 1ns/1ns

module tb_uart;

    localparam int DW = uart_pkg::DATA_BITS;
    localparam int CW = uart_pkg::CNT_BITS;
    localparam int BIT_T = uart_pkg::CLKS_PER_BIT;
    localparam int DEPTH = 2 ** uart_pkg::FIFO_LOG2_DEPTH;

    typedef enum {OP_IDLE, OP_SEND, OP_BURST, OP_RAW, OP_READ} op_e;

    logic          i_clk;
    logic          i_nrst;
    logic          i_tx_we;
    logic [DW-1:0] i_tx_wdata;
    logic          i_rx_re;
    logic [DW-1:0] o_rx_rdata;
    logic [CW-1:0] o_tx_count;
    logic [CW-1:0] o_rx_count;
    logic          o_frame_err;
    logic          o_txd;
    logic          rxd_drive;
    logic          loopback;
    longint        watchdog_ns = 0;

    // Stimulus table, one queue per column
    string         t_name[$];
    op_e           t_op[$];
    logic [DW-1:0] t_data[$];
    logic          t_stop[$];
    logic [CW-1:0] t_count[$];
    // Bytes expected out of the receive FIFO, oldest first
    logic [DW-1:0] ref_q[$];

    uart_top dut (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_tx_we     (i_tx_we),
        .i_tx_wdata  (i_tx_wdata),
        .o_tx_count  (o_tx_count),
        .i_rx_re     (i_rx_re),
        .o_rx_rdata  (o_rx_rdata),
        .o_rx_count  (o_rx_count),
        .o_frame_err (o_frame_err),
        .o_txd       (o_txd),
        .i_rxd       (loopback ? o_txd : rxd_drive)
    );

    always #2 i_clk = ~i_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [CW-1:0] exp, input logic [CW-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected count %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected flag %b, actual %b", name, exp, act));
        end
    endtask

    task automatic add_entry(input string name, input op_e op, input logic [DW-1:0] data,
                             input logic stop, input int cnt);
        t_name.push_back(name);
        t_op.push_back(op);
        t_data.push_back(data);
        t_stop.push_back(stop);
        t_count.push_back(CW'(cnt));
    endtask

    // Ends on the cycle the receiver pushes a byte or flags a bad stop bit
    task automatic wait_rx_done(input string name, input int limit, output logic err);
        int  n;
        logic seen;
        n = 0;
        seen = 1'b0;
        err = 1'b0;
        while (!seen) begin
            @(negedge i_clk);
            seen = dut.rx_we || o_frame_err;
            err = o_frame_err;
            n++;
            if (!seen && n >= limit) begin
                fail_run($sformatf("%s: receiver finished no frame within %0d cycles", name, limit));
            end
        end
    endtask

    // Writes n bytes in consecutive cycles and waits for them to loop back
    task automatic send_bytes(input string name, input int n, input logic [DW-1:0] first,
                              input logic [CW-1:0] exp);
        logic [DW-1:0] data;
        logic [CW-1:0] prev;
        logic          err;
        data = first;
        @(negedge i_clk);
        prev = o_tx_count;
        for (int k = 0; k <= n; k++) begin
            @(posedge i_clk);
            loopback <= 1'b1;
            i_tx_we <= (k < n);
            i_tx_wdata <= data;
            if (k < n && ref_q.size() < DEPTH) begin
                ref_q.push_back(data);
            end
            data = DW'($urandom);
            @(negedge i_clk);
            check_flag(name, 1'b1, o_tx_count <= prev + 1'b1);
            prev = o_tx_count;
        end
        for (int k = 0; k < n; k++) begin
            wait_rx_done(name, 12 * BIT_T, err);
            check_flag(name, 1'b0, err);
        end
        @(negedge i_clk);
        check_count(name, '0, o_tx_count);
        check_count(name, exp, o_rx_count);
    endtask

    task automatic raw_frame(input string name, input logic [DW-1:0] data, input logic stop,
                             input logic [CW-1:0] exp);
        logic [DW+1:0] bits;
        logic          err;
        bits = {stop, data, 1'b0};
        @(posedge i_clk);
        loopback <= 1'b0;
        fork
            begin
                for (int b = 0; b < DW + 2; b++) begin
                    rxd_drive <= bits[b];
                    repeat (BIT_T) @(posedge i_clk);
                end
                rxd_drive <= 1'b1;
            end
            wait_rx_done(name, 11 * BIT_T, err);
        join
        check_flag(name, !stop, err);
        if (stop && ref_q.size() < DEPTH) begin
            ref_q.push_back(data);
        end
        @(negedge i_clk);
        check_count(name, exp, o_rx_count);
    endtask

    task automatic read_byte(input string name, input logic [CW-1:0] exp);
        logic [DW-1:0] want;
        @(negedge i_clk);
        if (ref_q.size() == 0) begin
            fail_run($sformatf("%s: read requested but no byte is expected", name));
        end
        want = ref_q.pop_front();
        check_count(name, CW'(ref_q.size() + 1), o_rx_count);
        check_byte(name, want, o_rx_rdata);
        @(posedge i_clk);
        i_rx_re <= 1'b1;
        @(posedge i_clk);
        i_rx_re <= 1'b0;
        @(negedge i_clk);
        check_count(name, exp, o_rx_count);
    endtask

    initial begin
        i_clk = 1'b0;
        i_nrst = 1'b0;
        i_tx_we = 1'b0;
        i_tx_wdata = '0;
        i_rx_re = 1'b0;
        rxd_drive = 1'b1;
        loopback = 1'b0;
        void'($urandom(32'h500c));

        add_entry("reset_state", OP_IDLE, '0, 1'b1, 0);
        for (int k = 0; k < 4; k++) begin
            add_entry($sformatf("loop_send_%0d", k), OP_SEND, DW'($urandom), 1'b1, k + 1);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry($sformatf("loop_read_%0d", k), OP_READ, '0, 1'b1, 3 - k);
        end
        add_entry("burst_5", OP_BURST, DW'($urandom), 1'b1, 5);
        for (int k = 0; k < 5; k++) begin
            add_entry($sformatf("burst_read_%0d", k), OP_READ, '0, 1'b1, 4 - k);
        end
        // Two frames more than the receive FIFO holds
        for (int k = 0; k < DEPTH + 2; k++) begin
            add_entry($sformatf("fill_frame_%0d", k), OP_RAW, DW'($urandom), 1'b1,
                      (k < DEPTH) ? k + 1 : DEPTH);
        end
        for (int k = 0; k < DEPTH; k++) begin
            add_entry($sformatf("fill_read_%0d", k), OP_READ, '0, 1'b1, DEPTH - 1 - k);
        end
        add_entry("bad_stop", OP_RAW, 8'ha5, 1'b0, 0);
        add_entry("good_after_bad", OP_RAW, 8'h3c, 1'b1, 1);
        add_entry("good_after_bad_read", OP_READ, '0, 1'b1, 0);
        watchdog_ns = t_name.size() * 12 * BIT_T * 4 + 10 * 4;

        repeat (10) @(posedge i_clk);
        i_nrst <= 1'b1;

        for (int i = 0; i < t_name.size(); i++) begin
            case (t_op[i])
                OP_IDLE: begin
                    @(negedge i_clk);
                    check_flag(t_name[i], 1'b1, o_txd);
                    check_flag(t_name[i], 1'b0, o_frame_err);
                    check_count(t_name[i], t_count[i], o_tx_count);
                    check_count(t_name[i], t_count[i], o_rx_count);
                end
                OP_SEND:  send_bytes(t_name[i], 1, t_data[i], t_count[i]);
                OP_BURST: send_bytes(t_name[i], 5, t_data[i], t_count[i]);
                OP_RAW:   raw_frame(t_name[i], t_data[i], t_stop[i], t_count[i]);
                default:  read_byte(t_name[i], t_count[i]);
            endcase
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        fail_run($sformatf("Watchdog: run timed out after %0d ns", watchdog_ns));
    end

endmodule

// File: build.f
hw/uart_pkg.sv
hw/sfifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
testbench/tb_uart.sv

// File: run.sh
#!/bin/sh
# Build and run the serial port testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_uart -o sim_uart

status=0
./obj_dir/sim_uart > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
